/* rtl/uart_pkg.sv */
package uart_pkg;

    // ------------------------------
    // serial character format
    // ------------------------------
    localparam int char_bits = 8;               // 8n1 data bits.

    // ------------------------------
    // nmea zda sentence layout
    // ------------------------------
    localparam int tag_len = 6;                 // characters in the tag.

    // first tag character sits in the top byte.
    localparam logic [tag_len*char_bits-1:0] sentence_tag = "GPZDA,";

    localparam int info_len = 6;                // hhmmss after the tag.
    localparam int digits_per_field = 2;        // two ascii digits per field.

endpackage

/* rtl/time_pkg.sv */
package time_pkg;

    // ------------------------------
    // field widths
    // ------------------------------
    localparam int hour_bits   = 5;             // 0..23.
    localparam int min_bits    = 6;             // 0..59.
    localparam int sec_bits    = 6;             // 0..59.
    localparam int field_bits  = 7;             // holds any two-digit value.
    localparam int subsec_bits = 32;            // clock cycles since pps.

    // ------------------------------
    // rollover limits
    // ------------------------------
    localparam int last_hour   = 23;
    localparam int last_minute = 59;
    localparam int last_second = 59;

    // load order is hour, minute, second.
    localparam int n_fields = 3;

endpackage

/* rtl/uart_rx.sv */
module uart_rx #(
    parameter int clk_freq  = 25_000_000,
    parameter int baud_rate = 115_200
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rx_line,
    output logic [uart_pkg::char_bits-1:0] rx_data,
    output logic                           rx_valid
);
    import uart_pkg::*;

    localparam int bit_ticks  = clk_freq / baud_rate;
    localparam int half_ticks = bit_ticks / 2;
    localparam int cnt_bits   = $clog2(bit_ticks);
    localparam int idx_bits   = $clog2(char_bits);

    localparam logic [cnt_bits-1:0] half_limit = cnt_bits'(half_ticks - 1);
    localparam logic [cnt_bits-1:0] bit_limit  = cnt_bits'(bit_ticks - 1);
    localparam logic [idx_bits-1:0] last_bit   = idx_bits'(char_bits - 1);

    // receiver states.
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_start = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;
    localparam logic [1:0] st_stop  = 2'd3;

    logic [1:0]           line_sync;            // two-flop synchroniser.
    logic                 line_prev;            // for falling edge detect.
    logic                 line_s;
    logic                 line_fall;
    logic [1:0]           state;
    logic [cnt_bits-1:0]  tick_cnt;
    logic [cnt_bits-1:0]  tick_limit;
    logic                 tick_done;
    logic [idx_bits-1:0]  bit_idx;
    logic [char_bits-1:0] shift_reg;

    assign line_s     = line_sync[1];
    assign line_fall  = line_prev & ~line_s;
    assign tick_limit = (state == st_start) ? half_limit : bit_limit;
    assign tick_done  = (tick_cnt == tick_limit);

    // ------------------------------
    // line synchroniser
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            line_sync <= 2'b11;                 // line idles high.
            line_prev <= 1'b1;
        end else begin
            line_sync <= {line_sync[0], rx_line};
            line_prev <= line_s;
        end
    end

    // ------------------------------
    // bit timing and framing
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            tick_cnt <= tick_done ? '0 : tick_cnt + 1'b1;
            case (state)
                st_idle: begin
                    tick_cnt <= '0;
                    if (line_fall) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (tick_done) begin
                        bit_idx <= '0;
                        state   <= line_s ? st_idle : st_data;  // glitch check.
                    end
                end
                st_data: begin
                    if (tick_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == last_bit) begin
                            state <= st_stop;
                        end
                    end
                end
                default: begin
                    if (tick_done) begin
                        rx_valid <= line_s;     // drop the byte on a framing error.
                        state    <= st_idle;
                    end
                end
            endcase
        end
    end

    // data path, lsb first.
    always_ff @(posedge clk) begin
        if (state == st_data && tick_done) begin
            shift_reg <= {line_s, shift_reg[char_bits-1:1]};
        end
        if (state == st_stop && tick_done) begin
            rx_data <= shift_reg;
        end
    end

endmodule

/* rtl/pattern_search.sv */
module pattern_search (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [uart_pkg::char_bits-1:0] rx_data,
    input  logic                           rx_valid,
    output logic                           pattern_found,
    output logic [uart_pkg::char_bits-1:0] info_data,
    output logic                           info_valid
);
    import uart_pkg::*;

    localparam int idx_bits = $clog2(tag_len);
    localparam int cnt_bits = $clog2(info_len + 1);

    localparam logic [idx_bits-1:0]  last_idx   = idx_bits'(tag_len - 1);
    localparam logic [cnt_bits-1:0]  info_count = cnt_bits'(info_len);
    localparam logic [char_bits-1:0] first_char =
        sentence_tag[tag_len*char_bits-1 -: char_bits];

    logic [idx_bits-1:0]  match_idx;            // next tag character to compare.
    logic [cnt_bits-1:0]  info_left;            // bytes still to forward.
    logic [char_bits-1:0] tag_char;
    logic                 forwarding;

    // tag is stored first character in the top byte.
    assign tag_char   = sentence_tag[(tag_len - 1 - match_idx) * char_bits +: char_bits];
    assign forwarding = (info_left != '0);

    // ------------------------------
    // tag matcher and forward counter
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            match_idx     <= '0;
            info_left     <= '0;
            pattern_found <= 1'b0;
            info_valid    <= 1'b0;
        end else begin
            pattern_found <= 1'b0;
            info_valid    <= 1'b0;
            if (rx_valid) begin
                if (forwarding) begin
                    info_left  <= info_left - 1'b1;
                    info_valid <= 1'b1;
                end else if (rx_data == tag_char) begin
                    if (match_idx == last_idx) begin
                        match_idx     <= '0;
                        info_left     <= info_count;
                        pattern_found <= 1'b1;
                    end else begin
                        match_idx <= match_idx + 1'b1;
                    end
                end else if (rx_data == first_char) begin
                    match_idx <= idx_bits'(1);  // restart on a fresh 'G'.
                end else begin
                    match_idx <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && forwarding) begin
            info_data <= rx_data;
        end
    end

endmodule

/* rtl/ascii_to_bin.sv */
module ascii_to_bin (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [uart_pkg::char_bits-1:0]  digit,
    input  logic                            digit_valid,
    output logic [time_pkg::field_bits-1:0] field_value,
    output logic                            field_valid
);
    import uart_pkg::*;
    import time_pkg::*;

    localparam int cnt_bits = $clog2(digits_per_field + 1);

    localparam logic [cnt_bits-1:0]  last_digit = cnt_bits'(digits_per_field - 1);
    localparam logic [char_bits-1:0] ascii_zero = char_bits'(8'h30);

    logic [field_bits-1:0] acc;                 // partial value of the field.
    logic [field_bits-1:0] acc_next;
    logic [char_bits-1:0]  digit_off;
    logic [cnt_bits-1:0]   dig_cnt;

    assign digit_off = digit - ascii_zero;
    assign acc_next  = acc * field_bits'(10) + field_bits'(digit_off);

    always_ff @(posedge clk) begin
        if (rst) begin
            acc         <= '0;
            dig_cnt     <= '0;
            field_valid <= 1'b0;
        end else begin
            field_valid <= 1'b0;
            if (digit_valid) begin
                if (dig_cnt == last_digit) begin
                    acc         <= '0;          // ready for the next field.
                    dig_cnt     <= '0;
                    field_valid <= 1'b1;
                end else begin
                    acc     <= acc_next;
                    dig_cnt <= dig_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (digit_valid && dig_cnt == last_digit) begin
            field_value <= acc_next;
        end
    end

endmodule

/* rtl/pps_conditioner.sv */
module pps_conditioner #(
    parameter int debounce_len = 5
) (
    input  logic clk,
    input  logic rst,
    input  logic pps_in,
    output logic pps_rise
);

    logic [1:0]              pps_sync;          // two-flop synchroniser.
    logic [debounce_len-2:0] history;           // older synchronised samples.
    logic [debounce_len-1:0] window;            // newest sample plus history.
    logic                    level;
    logic                    level_q;

    assign window   = {history, pps_sync[1]};
    assign pps_rise = level & ~level_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pps_sync <= '0;
            history  <= '0;
            level    <= 1'b0;
            level_q  <= 1'b0;
        end else begin
            pps_sync <= {pps_sync[0], pps_in};
            history  <= window[debounce_len-2:0];
            level_q  <= level;
            if (&window) begin
                level <= 1'b1;
            end else if (~|window) begin
                level <= 1'b0;
            end
        end
    end

endmodule

/* rtl/time_of_day.sv */
module time_of_day (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [time_pkg::field_bits-1:0]  field_value,
    input  logic                             field_valid,
    input  logic                             pps_rise,
    output logic [time_pkg::hour_bits-1:0]   hour,
    output logic [time_pkg::min_bits-1:0]    minute,
    output logic [time_pkg::sec_bits-1:0]    second,
    output logic [time_pkg::subsec_bits-1:0] subsec,
    output logic                             time_valid
);
    import time_pkg::*;

    localparam int load_bits = $clog2(n_fields + 1);

    localparam logic [load_bits-1:0] load_done = load_bits'(n_fields);
    localparam logic [load_bits-1:0] load_hour = load_bits'(0);
    localparam logic [load_bits-1:0] load_min  = load_bits'(1);

    localparam logic [hour_bits-1:0] hour_wrap = hour_bits'(last_hour);
    localparam logic [min_bits-1:0]  min_wrap  = min_bits'(last_minute);
    localparam logic [sec_bits-1:0]  sec_wrap  = sec_bits'(last_second);

    logic [load_bits-1:0] load_cnt;             // which field loads next.
    logic                 loading;

    assign loading = (load_cnt != load_done);

    // ------------------------------
    // field load and second counter
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            load_cnt   <= '0;
            time_valid <= 1'b0;
            hour       <= '0;
            minute     <= '0;
            second     <= '0;
        end else begin
            time_valid <= ~loading;             // one cycle after the last field.
            if (loading) begin
                if (field_valid) begin
                    load_cnt <= load_cnt + 1'b1;
                    case (load_cnt)
                        load_hour: hour   <= hour_bits'(field_value);
                        load_min:  minute <= min_bits'(field_value);
                        default:   second <= sec_bits'(field_value);
                    endcase
                end
            end else if (time_valid && pps_rise) begin
                if (second == sec_wrap) begin
                    second <= '0;
                    if (minute == min_wrap) begin
                        minute <= '0;
                        hour   <= (hour == hour_wrap) ? '0 : hour + 1'b1;
                    end else begin
                        minute <= minute + 1'b1;
                    end
                end else begin
                    second <= second + 1'b1;
                end
            end
        end
    end

    // ------------------------------
    // sub-second counter
    // ------------------------------
    // runs before lock too, so the phase is known from the first pps.
    always_ff @(posedge clk) begin
        if (rst) begin
            subsec <= '0;
        end else if (pps_rise) begin
            subsec <= '0;
        end else begin
            subsec <= subsec + 1'b1;
        end
    end

endmodule

/* rtl/nmea_timestamp.sv */
module nmea_timestamp #(
    parameter int clk_freq     = 25_000_000,
    parameter int baud_rate    = 115_200,
    parameter int debounce_len = 5
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             uart_rx_line,
    input  logic                             pps_in,
    output logic                             pattern_found,
    output logic [time_pkg::hour_bits-1:0]   hour,
    output logic [time_pkg::min_bits-1:0]    minute,
    output logic [time_pkg::sec_bits-1:0]    second,
    output logic [time_pkg::subsec_bits-1:0] subsec,
    output logic                             time_valid,
    output logic                             pps_pulse
);
    import uart_pkg::*;
    import time_pkg::*;

    logic [char_bits-1:0]  rx_data;
    logic                  rx_valid;
    logic [char_bits-1:0]  info_data;
    logic                  info_valid;
    logic [field_bits-1:0] field_value;
    logic                  field_valid;
    logic                  pps_rise;

    assign pps_pulse = pps_rise;

    // ------------------------------
    // receive chain
    // ------------------------------
    uart_rx #(
        .clk_freq  (clk_freq),
        .baud_rate (baud_rate)
    ) u_uart_rx (
        .clk      (clk),
        .rst      (rst),
        .rx_line  (uart_rx_line),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    pattern_search u_pattern_search (
        .clk           (clk),
        .rst           (rst),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .pattern_found (pattern_found),
        .info_data     (info_data),
        .info_valid    (info_valid)
    );

    ascii_to_bin u_ascii_to_bin (
        .clk         (clk),
        .rst         (rst),
        .digit       (info_data),
        .digit_valid (info_valid),
        .field_value (field_value),
        .field_valid (field_valid)
    );

    // ------------------------------
    // pps path and time keeper
    // ------------------------------
    pps_conditioner #(
        .debounce_len (debounce_len)
    ) u_pps_conditioner (
        .clk      (clk),
        .rst      (rst),
        .pps_in   (pps_in),
        .pps_rise (pps_rise)
    );

    time_of_day u_time_of_day (
        .clk         (clk),
        .rst         (rst),
        .field_value (field_value),
        .field_valid (field_valid),
        .pps_rise    (pps_rise),
        .hour        (hour),
        .minute      (minute),
        .second      (second),
        .subsec      (subsec),
        .time_valid  (time_valid)
    );

endmodule

/* dv/nmea_timestamp_tb.sv */
module nmea_timestamp_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_freq      = 25_000_000;
    localparam int baud_rate     = 1_250_000;
    localparam int debounce_len  = 5;
    localparam int bit_clocks    = clk_freq / baud_rate;
    localparam int pulse_lat     = debounce_len + 2;   // sync flops plus edge register.
    localparam int n_rounds      = 3;
    localparam int n_filler      = 3;
    localparam int n_pre         = 2;                  // pps edges before the sentence.
    localparam int n_post        = 8;                  // pps edges after lock.
    localparam int char_cycles   = 10 * bit_clocks;
    localparam int edge_cycles   = pulse_lat + 96 + 8;
    localparam int glitch_cycles = 2 * debounce_len + 8;
    localparam int round_cycles  = (n_filler + 2) * 24 * char_cycles
                                 + (n_pre + n_post + 1) * edge_cycles
                                 + (n_pre + n_post) * glitch_cycles + 16;
    localparam int limit_cycles  = 2 * n_rounds * round_cycles;

    logic        clk;
    logic        rst;
    logic        uart_rx_line;
    logic        pps_in;
    logic        pattern_found;
    logic [4:0]  hour;
    logic [5:0]  minute;
    logic [5:0]  second;
    logic [31:0] subsec;
    logic        time_valid;
    logic        pps_pulse;

    logic [31:0] lfsr;
    int          found_count = 0;
    int          expect_found;
    int          model_h;
    int          model_m;
    int          model_s;
    logic        model_locked;

    nmea_timestamp #(
        .clk_freq     (clk_freq),
        .baud_rate    (baud_rate),
        .debounce_len (debounce_len)
    ) dut (
        .clk           (clk),
        .rst           (rst),
        .uart_rx_line  (uart_rx_line),
        .pps_in        (pps_in),
        .pattern_found (pattern_found),
        .hour          (hour),
        .minute        (minute),
        .second        (second),
        .subsec        (subsec),
        .time_valid    (time_valid),
        .pps_pulse     (pps_pulse)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = (lfsr >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_bit()};
        end
        return value;
    endfunction

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s actual 0x%0h expected 0x%0h", name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic step_model();
        if (model_s < 59) begin
            model_s++;
        end else begin
            model_s = 0;
            if (model_m < 59) begin
                model_m++;
            end else begin
                model_m = 0;
                model_h = (model_h + 1) % 24;
            end
        end
    endtask

    // compares the visible state with the model, then lines up on a rising edge.
    task automatic check_state();
        @(negedge clk);
        check_val("pattern_found count", found_count, expect_found);
        check_val("time_valid", time_valid, model_locked);
        check_val("hour", hour, model_h);
        check_val("minute", minute, model_m);
        check_val("second", second, model_s);
        @(posedge clk);
    endtask

    // ------------------------------
    // uart driver
    // ------------------------------
    task automatic send_bit(input logic value);
        uart_rx_line <= value;
        repeat (bit_clocks) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] data);
        send_bit(1'b0);                                 // start bit.
        for (int i = 0; i < 8; i++) begin
            send_bit(data[i]);
        end
        send_bit(1'b1);                                 // stop bit.
    endtask

    task automatic send_text(input string text);
        for (int i = 0; i < text.len(); i++) begin
            send_byte(text[i]);
        end
    endtask

    task automatic send_filler();
        int          n;
        logic [31:0] c;
        case (rand_bits(3) % 5)
            0: send_text("$GPGGA,");
            1: send_text("$GPZDB,");                    // near miss on the last letter.
            2: send_text("$GNZDA,");
            3: send_text("$GPRMC,");
            default: send_text("$GPZZDA,");
        endcase
        n = 4 + rand_bits(3);
        for (int i = 0; i < n; i++) begin
            c = rand_bits(4);
            send_byte(c < 10 ? 8'h30 + c : 8'h2c);      // digit or comma.
        end
        send_byte(8'h0d);
        send_byte(8'h0a);
    endtask

    task automatic send_zda(input int hh, input int mm, input int ss);
        send_text("$GPZDA,");
        send_byte(8'h30 + hh / 10);
        send_byte(8'h30 + hh % 10);
        send_byte(8'h30 + mm / 10);
        send_byte(8'h30 + mm % 10);
        send_byte(8'h30 + ss / 10);
        send_byte(8'h30 + ss % 10);
        send_text(".00,,,,*");
        send_byte(8'h0d);
        send_byte(8'h0a);
    endtask

    // ------------------------------
    // pps driver
    // ------------------------------
    task automatic pps_edge();
        int gap;
        pps_in <= 1'b1;
        for (int k = 0; k <= pulse_lat; k++) begin
            @(negedge clk);
            check_val("pps_pulse", pps_pulse, k == pulse_lat);
        end
        if (model_locked) begin
            step_model();
        end
        gap = 24 + rand_bits(6);
        for (int k = 0; k < gap; k++) begin
            @(posedge clk);
            if (k == 10) begin
                pps_in <= 1'b0;
            end
            @(negedge clk);
            check_val("subsec", subsec, k);             // zero in the cycle after the pulse.
            check_val("pps_pulse", pps_pulse, 1'b0);
            if (k == 0) begin
                check_val("second", second, model_s);
            end
        end
        @(posedge clk);
        check_state();
    endtask

    task automatic pps_glitch();
        int len;
        len = 1 + rand_bits(4) % (debounce_len - 1);
        pps_in <= 1'b1;
        repeat (len) @(posedge clk);
        pps_in <= 1'b0;
        for (int k = 0; k < pulse_lat + 4; k++) begin
            @(negedge clk);
            check_val("pps_pulse", pps_pulse, 1'b0);
        end
        @(posedge clk);
        check_state();
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    task automatic apply_reset();
        rst          <= 1'b1;
        uart_rx_line <= 1'b1;
        pps_in       <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val("time_valid", time_valid, 1'b0);
        check_val("pattern_found", pattern_found, 1'b0);
        check_val("pps_pulse", pps_pulse, 1'b0);
        check_val("hour", hour, 0);
        check_val("minute", minute, 0);
        check_val("second", second, 0);
        check_val("subsec", subsec, 0);
        @(posedge clk);
    endtask

    task automatic run_round(input int hh, input int mm, input int ss);
        apply_reset();
        model_h      = 0;
        model_m      = 0;
        model_s      = 0;
        model_locked = 1'b0;
        for (int k = 0; k < n_filler; k++) begin
            send_filler();
            check_state();
        end
        for (int k = 0; k < n_pre; k++) begin
            pps_glitch();
            pps_edge();                                 // fields stay zero before lock.
        end
        send_zda(hh, mm, ss);
        expect_found++;
        model_h      = hh;
        model_m      = mm;
        model_s      = ss;
        model_locked = 1'b1;
        check_state();
        for (int k = 0; k < n_post; k++) begin
            pps_glitch();
            pps_edge();
        end
        send_zda((hh + 7) % 24, (mm + 13) % 60, (ss + 29) % 60);
        expect_found++;                                 // found again but not reloaded.
        check_state();
        pps_edge();
    endtask

    always @(negedge clk) begin
        if (!rst && pattern_found) begin
            found_count <= found_count + 1;
        end
    end

    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("ERROR: timeout, the run did not finish within %0d clock cycles", limit_cycles);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int hh;
        int mm;
        int ss;
        rst          = 1'b1;
        uart_rx_line = 1'b1;
        pps_in       = 1'b0;
        lfsr         = 32'h9798;
        expect_found = 0;
        hh = rand_bits(8) % 24;
        mm = rand_bits(8) % 60;
        ss = rand_bits(8) % 60;
        run_round(hh, mm, ss);
        hh = rand_bits(8) % 24;                         // minute and hour carry.
        ss = 52 + rand_bits(2);
        run_round(hh, 59, ss);
        ss = 52 + rand_bits(2);                         // midnight wrap.
        run_round(23, 59, ss);
        $display("All tests passed");
        $finish;
    end

endmodule

/* build.f */
rtl/uart_pkg.sv
rtl/time_pkg.sv
rtl/uart_rx.sv
rtl/pattern_search.sv
rtl/ascii_to_bin.sv
rtl/pps_conditioner.sv
rtl/time_of_day.sv
rtl/nmea_timestamp.sv
dv/nmea_timestamp_tb.sv
